// ==== hdl/dram_ctrl_pkg.sv ====
// shared address layout, DRAM timing and command encoding, referenced by scoped names
`default_nettype none

package dram_ctrl_pkg;

	// address split, lsb first: column, bank, bank group, row
	localparam int COL_WIDTH  = 6; // bits 5..0
	localparam int BANK_WIDTH = 2; // bits 7..6
	localparam int BG_WIDTH   = 2; // bits 9..8
	localparam int ROW_WIDTH  = 6; // bits 15..10
	localparam int ADDR_WIDTH = COL_WIDTH + BANK_WIDTH + BG_WIDTH + ROW_WIDTH;

	// every bank group holds the same number of banks
	localparam int NUM_BANKS = 2 ** (BG_WIDTH + BANK_WIDTH);

	// per-bank and tCCD countdowns share this width
	localparam int TIMER_WIDTH = 5;

	// timing in clk cycles
	localparam logic [TIMER_WIDTH-1:0] T_RCD = 5'd3; // act -> rd/wr, same bank
	localparam logic [TIMER_WIDTH-1:0] T_RP  = 5'd3; // pre -> act, same bank
	localparam logic [TIMER_WIDTH-1:0] T_RAS = 5'd8; // act -> pre, same bank
	localparam logic [TIMER_WIDTH-1:0] T_CCD = 5'd2; // rd/wr -> rd/wr, any bank

	// refresh interval and recovery are far longer than the bank timers
	localparam int T_REFI = 200;
	localparam int T_RFC  = 12;  // no command at all during this window

	// command opcodes on the command port
	typedef enum logic [2:0] {
		CMD_RD,  // column read, row field zero
		CMD_WR,  // column write, row field zero
		CMD_ACT, // open a row, column field zero
		CMD_PRE, // close the bank, row and column zero
		CMD_REF  // all-bank refresh, address fields zero
	} dram_cmd_t;

endpackage : dram_ctrl_pkg

`default_nettype wire

// ==== hdl/request_queue.sv ====
// in-order request FIFO between the request port and the command sequencer
`timescale 1ns/100ps
`default_nettype none

module request_queue #(
	parameter int DEPTH = 8 // power of two
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                push_valid,
	input  logic                                push_write, // 1 = write, 0 = read
	input  logic [dram_ctrl_pkg::ADDR_WIDTH-1:0] push_addr,
	input  logic                                pop,        // head consumed this cycle
	output logic                                push_ready,
	output logic                                head_valid,
	output logic                                head_write,
	output logic [dram_ctrl_pkg::ADDR_WIDTH-1:0] head_addr
);

	localparam int PTR_WIDTH = $clog2(DEPTH);

	logic [dram_ctrl_pkg::ADDR_WIDTH-1:0] addr_mem [DEPTH];
	logic                                write_mem [DEPTH];

	logic [PTR_WIDTH-1:0] wr_ptr;  // wraps on its own since depth is 2^n
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH:0]   count;   // one extra bit to hold DEPTH
	logic                 push_fire;
	logic                 pop_fire;

	assign push_ready = (count != (PTR_WIDTH+1)'(DEPTH)); // low only when full
	assign head_valid = (count != '0);
	assign push_fire  = push_valid && push_ready;
	assign pop_fire   = pop && head_valid; // ignore a stray pop on empty

	assign head_write = write_mem[rd_ptr]; // oldest entry
	assign head_addr  = addr_mem[rd_ptr];

	// storage, written only on an accepted request
	always_ff @(posedge clk) begin
		if (push_fire) begin
			addr_mem[wr_ptr]  <= push_addr;
			write_mem[wr_ptr] <= push_write;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_fire && !pop_fire)
				count <= count + 1'b1;
			else if (pop_fire && !push_fire)
				count <= count - 1'b1; // push and pop together leave count alone
		end
	end

endmodule : request_queue

`default_nettype wire

// ==== hdl/bank_state.sv ====
// per-bank open-row tracking and timing countdowns, queried for the head request's bank
`timescale 1ns/100ps
`default_nettype none

module bank_state (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic                                                  issue_fire, // cmd handshake
	input  dram_ctrl_pkg::dram_cmd_t                              issue_op,
	input  logic [dram_ctrl_pkg::BG_WIDTH+dram_ctrl_pkg::BANK_WIDTH-1:0] issue_bank,
	input  logic [dram_ctrl_pkg::ROW_WIDTH-1:0]                   issue_row,
	input  logic [dram_ctrl_pkg::BG_WIDTH+dram_ctrl_pkg::BANK_WIDTH-1:0] query_bank,
	output logic                                                  open,
	output logic [dram_ctrl_pkg::ROW_WIDTH-1:0]                   open_row,
	output logic                                                  act_ok,
	output logic                                                  pre_ok,
	output logic                                                  rw_ok
);

	logic                                   open_q    [dram_ctrl_pkg::NUM_BANKS];
	logic [dram_ctrl_pkg::ROW_WIDTH-1:0]    row_q     [dram_ctrl_pkg::NUM_BANKS];
	// tRCD after act, tRP after pre; never both live at once
	logic [dram_ctrl_pkg::TIMER_WIDTH-1:0]  delay_cnt [dram_ctrl_pkg::NUM_BANKS];
	logic [dram_ctrl_pkg::TIMER_WIDTH-1:0]  ras_cnt   [dram_ctrl_pkg::NUM_BANKS];

	// open flag and countdowns
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < dram_ctrl_pkg::NUM_BANKS; b++) begin
				open_q[b]    <= 1'b0; // all banks start precharged
				delay_cnt[b] <= '0;
				ras_cnt[b]   <= '0;
			end
		end else begin
			for (int b = 0; b < dram_ctrl_pkg::NUM_BANKS; b++) begin
				if (delay_cnt[b] != '0)
					delay_cnt[b] <= delay_cnt[b] - 1'b1; // saturate at zero
				if (ras_cnt[b] != '0)
					ras_cnt[b] <= ras_cnt[b] - 1'b1;
			end
			if (issue_fire) begin
				case (issue_op)
					dram_ctrl_pkg::CMD_ACT: begin
						open_q[issue_bank]    <= 1'b1;
						delay_cnt[issue_bank] <= dram_ctrl_pkg::T_RCD; // load wins over decrement
						ras_cnt[issue_bank]   <= dram_ctrl_pkg::T_RAS;
					end
					dram_ctrl_pkg::CMD_PRE: begin
						open_q[issue_bank]    <= 1'b0;
						delay_cnt[issue_bank] <= dram_ctrl_pkg::T_RP;
					end
					dram_ctrl_pkg::CMD_REF: begin
						// refresh leaves every bank closed
						for (int b = 0; b < dram_ctrl_pkg::NUM_BANKS; b++)
							open_q[b] <= 1'b0;
					end
					default: ; // rd/wr change no bank state
				endcase
			end
		end
	end

	// row address latched on act, only meaningful while open
	always_ff @(posedge clk) begin
		if (issue_fire && issue_op == dram_ctrl_pkg::CMD_ACT)
			row_q[issue_bank] <= issue_row;
	end

	assign open     = open_q[query_bank];
	assign open_row = row_q[query_bank];
	assign act_ok   = !open_q[query_bank] && (delay_cnt[query_bank] == '0); // tRP met
	assign pre_ok   = open_q[query_bank] && (ras_cnt[query_bank] == '0);    // tRAS met
	assign rw_ok    = open_q[query_bank] && (delay_cnt[query_bank] == '0);  // tRCD met

endmodule : bank_state

`default_nettype wire

// ==== hdl/refresh_timer.sv ====
// refresh interval counter with refresh request and recovery hold-off
`timescale 1ns/100ps
`default_nettype none

module refresh_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic refresh_fire, // REF handshake from the sequencer
	output logic refresh_due,  // held until REF goes out
	output logic refresh_busy  // recovery window, tRFC long
);

	localparam int REFI_WIDTH = $clog2(dram_ctrl_pkg::T_REFI + 1);
	localparam int RFC_WIDTH  = $clog2(dram_ctrl_pkg::T_RFC + 1);

	logic [REFI_WIDTH-1:0] refi_cnt;
	logic [RFC_WIDTH-1:0]  rfc_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt     <= REFI_WIDTH'(dram_ctrl_pkg::T_REFI - 1);
			rfc_cnt      <= '0;
			refresh_due  <= 1'b0;
			refresh_busy <= 1'b0;
		end else if (refresh_busy) begin
			if (rfc_cnt == '0) begin
				refresh_busy <= 1'b0; // recovery over, interval restarts here
				refi_cnt     <= REFI_WIDTH'(dram_ctrl_pkg::T_REFI - 1);
			end else begin
				rfc_cnt <= rfc_cnt - 1'b1;
			end
		end else if (refresh_due) begin
			if (refresh_fire) begin
				refresh_due  <= 1'b0;
				refresh_busy <= 1'b1;
				rfc_cnt      <= RFC_WIDTH'(dram_ctrl_pkg::T_RFC - 1);
			end
		end else if (refi_cnt == '0) begin
			refresh_due <= 1'b1; // interval elapsed
		end else begin
			refi_cnt <= refi_cnt - 1'b1;
		end
	end

endmodule : refresh_timer

`default_nettype wire

// ==== hdl/command_sequencer.sv ====
// picks the next DRAM command for the head request or refresh and drives the command port
`timescale 1ns/100ps
`default_nettype none

module command_sequencer (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic                                                  head_valid,
	input  logic                                                  head_write,
	input  logic [dram_ctrl_pkg::ADDR_WIDTH-1:0]                  head_addr,
	input  logic                                                  open,     // head bank state
	input  logic [dram_ctrl_pkg::ROW_WIDTH-1:0]                   open_row,
	input  logic                                                  act_ok,
	input  logic                                                  pre_ok,
	input  logic                                                  rw_ok,
	input  logic                                                  refresh_due,
	input  logic                                                  refresh_busy,
	input  logic                                                  cmd_ready,
	output logic                                                  head_pop,
	output logic [dram_ctrl_pkg::BG_WIDTH+dram_ctrl_pkg::BANK_WIDTH-1:0] query_bank,
	output logic                                                  issue_fire,
	output dram_ctrl_pkg::dram_cmd_t                              issue_op,
	output logic [dram_ctrl_pkg::BG_WIDTH+dram_ctrl_pkg::BANK_WIDTH-1:0] issue_bank,
	output logic [dram_ctrl_pkg::ROW_WIDTH-1:0]                   issue_row,
	output logic                                                  refresh_fire,
	output logic                                                  cmd_valid,
	output dram_ctrl_pkg::dram_cmd_t                              cmd_op,
	output logic [dram_ctrl_pkg::BG_WIDTH-1:0]                    cmd_bg,
	output logic [dram_ctrl_pkg::BANK_WIDTH-1:0]                  cmd_bank,
	output logic [dram_ctrl_pkg::ROW_WIDTH-1:0]                   cmd_row,
	output logic [dram_ctrl_pkg::COL_WIDTH-1:0]                   cmd_col
);

	logic [dram_ctrl_pkg::COL_WIDTH-1:0]   head_col;
	logic [dram_ctrl_pkg::BANK_WIDTH-1:0]  head_bank;
	logic [dram_ctrl_pkg::BG_WIDTH-1:0]    head_bg;
	logic [dram_ctrl_pkg::ROW_WIDTH-1:0]   head_row;
	logic [dram_ctrl_pkg::TIMER_WIDTH-1:0] ccd_cnt;  // gap between column commands
	logic                                  cmd_fire;
	logic                                  cmd_is_rw;
	logic                                  launch;   // a new command is chosen this cycle
	dram_ctrl_pkg::dram_cmd_t              next_op;

	// address split: row | bg | bank | col
	assign head_col   = head_addr[dram_ctrl_pkg::COL_WIDTH-1:0];
	assign head_bank  = head_addr[dram_ctrl_pkg::COL_WIDTH +: dram_ctrl_pkg::BANK_WIDTH];
	assign head_bg    = head_addr[dram_ctrl_pkg::COL_WIDTH + dram_ctrl_pkg::BANK_WIDTH +:
	                              dram_ctrl_pkg::BG_WIDTH];
	assign head_row   = head_addr[dram_ctrl_pkg::ADDR_WIDTH-1 -: dram_ctrl_pkg::ROW_WIDTH];
	assign query_bank = {head_bg, head_bank};

	assign cmd_fire   = cmd_valid && cmd_ready;
	assign cmd_is_rw  = (cmd_op == dram_ctrl_pkg::CMD_RD) || (cmd_op == dram_ctrl_pkg::CMD_WR);

	// handshake reports, all from registered command fields
	assign issue_fire   = cmd_fire;
	assign issue_op     = cmd_op;
	assign issue_bank   = {cmd_bg, cmd_bank};
	assign issue_row    = cmd_row;
	assign refresh_fire = cmd_fire && (cmd_op == dram_ctrl_pkg::CMD_REF);
	assign head_pop     = cmd_fire && cmd_is_rw; // request done once its column cmd goes

	// command choice, only with nothing outstanding and refresh recovery over
	always_comb begin
		launch  = 1'b0;
		next_op = dram_ctrl_pkg::CMD_REF;
		if (!cmd_valid && !refresh_busy) begin
			if (refresh_due) begin
				launch = 1'b1; // refresh beats any request
			end else if (head_valid) begin
				if (open && open_row == head_row) begin
					launch  = rw_ok && (ccd_cnt == '0); // row hit
					next_op = head_write ? dram_ctrl_pkg::CMD_WR : dram_ctrl_pkg::CMD_RD;
				end else if (open) begin
					launch  = pre_ok; // row conflict, close first
					next_op = dram_ctrl_pkg::CMD_PRE;
				end else begin
					launch  = act_ok; // bank closed
					next_op = dram_ctrl_pkg::CMD_ACT;
				end
			end
		end
	end

	// valid flag and tCCD countdown
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_valid <= 1'b0;
			ccd_cnt   <= '0;
		end else begin
			if (cmd_fire)
				cmd_valid <= 1'b0;
			else if (launch)
				cmd_valid <= 1'b1;
			if (cmd_fire && cmd_is_rw)
				ccd_cnt <= dram_ctrl_pkg::T_CCD;
			else if (ccd_cnt != '0)
				ccd_cnt <= ccd_cnt - 1'b1;
		end
	end

	// command fields, held while waiting on cmd_ready
	always_ff @(posedge clk) begin
		if (launch) begin
			cmd_op   <= next_op;
			cmd_bg   <= (next_op == dram_ctrl_pkg::CMD_REF) ? '0 : head_bg;
			cmd_bank <= (next_op == dram_ctrl_pkg::CMD_REF) ? '0 : head_bank;
			cmd_row  <= (next_op == dram_ctrl_pkg::CMD_ACT) ? head_row : '0; // act only
			cmd_col  <= (next_op == dram_ctrl_pkg::CMD_RD ||
			             next_op == dram_ctrl_pkg::CMD_WR) ? head_col : '0;
		end
	end

endmodule : command_sequencer

`default_nettype wire

// ==== hdl/dram_ctrl_top.sv ====
// controller top level, connects queue, bank tracking, refresh and command sequencing
`timescale 1ns/100ps
`default_nettype none

module dram_ctrl_top #(
	parameter int QUEUE_DEPTH = 8 // request queue entries, power of two
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 req_valid,
	input  logic                                 req_write,
	input  logic [dram_ctrl_pkg::ADDR_WIDTH-1:0] req_addr,
	input  logic                                 cmd_ready,
	output logic                                 req_ready,
	output logic                                 cmd_valid,
	output dram_ctrl_pkg::dram_cmd_t             cmd_op,
	output logic [dram_ctrl_pkg::BG_WIDTH-1:0]   cmd_bg,
	output logic [dram_ctrl_pkg::BANK_WIDTH-1:0] cmd_bank,
	output logic [dram_ctrl_pkg::ROW_WIDTH-1:0]  cmd_row,
	output logic [dram_ctrl_pkg::COL_WIDTH-1:0]  cmd_col
);

	localparam int BANK_IDX_WIDTH = dram_ctrl_pkg::BG_WIDTH + dram_ctrl_pkg::BANK_WIDTH;

	logic                                 head_valid, head_write, head_pop;
	logic [dram_ctrl_pkg::ADDR_WIDTH-1:0] head_addr;
	logic [BANK_IDX_WIDTH-1:0]            query_bank, issue_bank; // {bg, bank}
	logic                                 open, act_ok, pre_ok, rw_ok;
	logic [dram_ctrl_pkg::ROW_WIDTH-1:0]  open_row, issue_row;
	logic                                 issue_fire;
	dram_ctrl_pkg::dram_cmd_t             issue_op;
	logic                                 refresh_due, refresh_busy, refresh_fire;

	request_queue #(.DEPTH(QUEUE_DEPTH)) u_request_queue (
		.clk, .rst_n,
		.push_valid(req_valid), .push_write(req_write), .push_addr(req_addr),
		.pop(head_pop), .push_ready(req_ready),
		.head_valid, .head_write, .head_addr
	);

	bank_state u_bank_state (
		.clk, .rst_n, .issue_fire, .issue_op, .issue_bank, .issue_row,
		.query_bank, .open, .open_row, .act_ok, .pre_ok, .rw_ok
	);

	refresh_timer u_refresh_timer (.clk, .rst_n, .refresh_fire, .refresh_due, .refresh_busy);

	command_sequencer u_command_sequencer (
		.clk, .rst_n, .head_valid, .head_write, .head_addr,
		.open, .open_row, .act_ok, .pre_ok, .rw_ok,
		.refresh_due, .refresh_busy, .cmd_ready,
		.head_pop, .query_bank, .issue_fire, .issue_op, .issue_bank, .issue_row,
		.refresh_fire, .cmd_valid, .cmd_op, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col
	);

endmodule : dram_ctrl_top

`default_nettype wire

// ==== sim/dram_ctrl_properties.sv ====
// command-port assertions, bound into the command sequencer by the bind at the end
`timescale 1ns/100ps
`default_nettype none

module dram_ctrl_properties (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic                                 cmd_valid,
	input logic                                 cmd_ready,
	input dram_ctrl_pkg::dram_cmd_t             cmd_op,
	input logic [dram_ctrl_pkg::BG_WIDTH-1:0]   cmd_bg,
	input logic [dram_ctrl_pkg::BANK_WIDTH-1:0] cmd_bank,
	input logic [dram_ctrl_pkg::ROW_WIDTH-1:0]  cmd_row,
	input logic [dram_ctrl_pkg::COL_WIDTH-1:0]  cmd_col,
	input logic                                 refresh_busy
);

	logic       rw_fire;
	logic [7:0] since_rw; // cycles since the last RD/WR handshake, saturates

	assign rw_fire = cmd_valid && cmd_ready &&
	                 (cmd_op == dram_ctrl_pkg::CMD_RD || cmd_op == dram_ctrl_pkg::CMD_WR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			since_rw <= 8'hff;
		else if (rw_fire)
			since_rw <= 8'd1;
		else if (since_rw != 8'hff)
			since_rw <= since_rw + 8'd1;
	end

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_bg) &&
		$stable(cmd_bank) && $stable(cmd_row) && $stable(cmd_col))
		else $error("command changed while stalled");

	ccd_gap: assert property (@(posedge clk) disable iff (!rst_n)
		rw_fire |-> since_rw >= 8'(dram_ctrl_pkg::T_CCD))
		else $error("RD/WR closer than tCCD");

	rfc_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		refresh_busy |-> !cmd_valid)
		else $error("command valid during refresh recovery");

endmodule : dram_ctrl_properties

bind command_sequencer dram_ctrl_properties u_dram_ctrl_properties (
	.clk, .rst_n, .cmd_valid, .cmd_ready, .cmd_op, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col,
	.refresh_busy
);

`default_nettype wire

// ==== sim/dram_ctrl_tb.sv ====
// directed testbench for the DRAM command controller; a command monitor checks every handshake
`timescale 1ns/100ps
`default_nettype none

module dram_ctrl_tb;

	localparam int QUEUE_DEPTH    = 8;    // DUT default depth
	localparam int TIMEOUT_CYCLES = 4000; // about three times the estimated length of the six tests
	localparam int NB             = dram_ctrl_pkg::NUM_BANKS;

	logic                                 clk = 1'b0;
	logic                                 rst_n;
	logic                                 req_valid;
	logic                                 req_write;
	logic [dram_ctrl_pkg::ADDR_WIDTH-1:0] req_addr;
	logic                                 req_ready;
	logic                                 cmd_ready;
	logic                                 cmd_valid;
	dram_ctrl_pkg::dram_cmd_t             cmd_op;
	logic [dram_ctrl_pkg::BG_WIDTH-1:0]   cmd_bg;
	logic [dram_ctrl_pkg::BANK_WIDTH-1:0] cmd_bank;
	logic [dram_ctrl_pkg::ROW_WIDTH-1:0]  cmd_row;
	logic [dram_ctrl_pkg::COL_WIDTH-1:0]  cmd_col;

	// requests in arrival order, the monitor walks them with exp_head
	logic        exp_write [$];
	logic [15:0] exp_addr [$];
	int          exp_head;

	// reference model of the banks, written by the monitor only
	logic       mdl_open [NB] = '{default: 1'b0};
	logic [5:0] mdl_row [NB];
	int         act_at [NB] = '{default: -1000}; // cycle of last ACT per bank
	int         pre_at [NB] = '{default: -1000};
	int         rw_at = -1000;
	int         ref_at = -1000;
	int         n_act, n_pre, n_rw, n_ref, n_cmd;
	int         cycle;
	int         mon_errors;
	int         test_errors;
	logic       jitter; // random cmd_ready while set

	dram_ctrl_top u_dram_ctrl_top (
		.clk, .rst_n, .req_valid, .req_write, .req_addr, .cmd_ready,
		.req_ready, .cmd_valid, .cmd_op, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic report_mismatch(string name, int got, int exp, inout int errs);
		$display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		errs++;
	endtask

	task automatic fail_note(string msg, inout int errs);
		$display("ERROR at %0t: %s", $time, msg);
		errs++;
	endtask

	task automatic end_run();
		$display("summary: %0d requests, %0d commands, %0d monitor errors, %0d test errors",
		         exp_addr.size(), n_cmd, mon_errors, test_errors);
		if (mon_errors + test_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	// address layout: row 15..10, bank group and bank 9..6, column 5..0
	function automatic logic [15:0] make_addr(int row, int bank, int col);
		return {6'(row), 4'(bank), 6'(col)};
	endfunction

	// small row and bank range so hits and conflicts both show up
	function automatic logic [15:0] random_addr();
		return make_addr($urandom_range(0, 3), $urandom_range(0, 3), $urandom_range(0, 63));
	endfunction

	task automatic check_command();
		int                       b;
		logic [15:0]              a;
		dram_ctrl_pkg::dram_cmd_t exp_op;
		n_cmd++;
		if (cmd_op == dram_ctrl_pkg::CMD_RD || cmd_op == dram_ctrl_pkg::CMD_WR)
			n_rw++; // every column command on the port, matched to a request or not
		b = int'({cmd_bg, cmd_bank});
		if (cmd_op == dram_ctrl_pkg::CMD_REF) begin
			if ({cmd_bg, cmd_bank, cmd_row, cmd_col} != '0)
				fail_note("REF with a nonzero address", mon_errors);
			mdl_open = '{default: 1'b0}; // refresh closes every row
			ref_at = cycle;
			n_ref++;
		end else if (exp_head >= exp_addr.size()) begin
			fail_note($sformatf("%s with no request pending", cmd_op.name()), mon_errors);
		end else begin
			a = exp_addr[exp_head];
			exp_op = exp_write[exp_head] ? dram_ctrl_pkg::CMD_WR : dram_ctrl_pkg::CMD_RD;
			if (cycle - ref_at <= dram_ctrl_pkg::T_RFC)
				fail_note("command inside the refresh recovery time", mon_errors);
			if (b != int'(a[9:6]))
				report_mismatch("cmd_bg/cmd_bank", b, int'(a[9:6]), mon_errors);
			case (cmd_op)
				dram_ctrl_pkg::CMD_ACT: begin
					if (mdl_open[b])
						fail_note("ACT to a bank that is already open", mon_errors);
					if (cmd_row != a[15:10])
						report_mismatch("cmd_row", int'(cmd_row), int'(a[15:10]), mon_errors);
					if (cmd_col != '0)
						report_mismatch("cmd_col", int'(cmd_col), 0, mon_errors);
					if (cycle - pre_at[b] < int'(dram_ctrl_pkg::T_RP))
						fail_note("ACT sooner than tRP after PRE", mon_errors);
					mdl_open[b] = 1'b1;
					mdl_row[b]  = cmd_row;
					act_at[b]   = cycle;
					n_act++;
				end
				dram_ctrl_pkg::CMD_PRE: begin
					if (!mdl_open[b] || mdl_row[b] == a[15:10])
						fail_note("PRE without a row conflict", mon_errors);
					if ({cmd_row, cmd_col} != '0)
						report_mismatch("cmd_row/cmd_col", int'({cmd_row, cmd_col}), 0, mon_errors);
					if (cycle - act_at[b] < int'(dram_ctrl_pkg::T_RAS))
						fail_note("PRE sooner than tRAS after ACT", mon_errors);
					mdl_open[b] = 1'b0;
					pre_at[b]   = cycle;
					n_pre++;
				end
				default: begin // RD or WR, completes the head request
					if (cmd_op != exp_op)
						report_mismatch("cmd_op", int'(cmd_op), int'(exp_op), mon_errors);
					if (!mdl_open[b] || mdl_row[b] != a[15:10])
						fail_note("column command without its row open", mon_errors);
					if (cmd_col != a[5:0])
						report_mismatch("cmd_col", int'(cmd_col), int'(a[5:0]), mon_errors);
					if (cmd_row != '0)
						report_mismatch("cmd_row", int'(cmd_row), 0, mon_errors);
					if (cycle - act_at[b] < int'(dram_ctrl_pkg::T_RCD))
						fail_note("column command sooner than tRCD after ACT", mon_errors);
					if (cycle - rw_at < int'(dram_ctrl_pkg::T_CCD))
						fail_note("column commands closer than tCCD", mon_errors);
					rw_at = cycle;
					exp_head++;
				end
			endcase
		end
	endtask

	// monitor, cycle count and timeout
	always @(posedge clk) begin
		cycle++;
		if (cycle >= TIMEOUT_CYCLES) begin
			fail_note("timeout, the tests did not finish", mon_errors);
			end_run();
		end else if (rst_n && cmd_valid && cmd_ready) begin
			check_command();
		end
	end

	task automatic step(); // one falling edge, inputs change here
		@(negedge clk);
		if (jitter)
			cmd_ready = 1'($urandom_range(0, 1));
	endtask

	task automatic send_req(logic write, logic [15:0] addr);
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		while (!req_ready)
			step();
		exp_write.push_back(write); // transfers on the coming rising edge
		exp_addr.push_back(addr);
		step();
		req_valid = 1'b0;
	endtask

	task automatic drain(); // until every request got its RD or WR
		while (exp_head < exp_addr.size() || cmd_valid)
			step();
		repeat (2) step();
	endtask

	task automatic row_miss_test();
		int acts;
		acts = n_act;
		send_req(1'b0, make_addr(5, 3, 17));
		send_req(1'b1, make_addr(9, 10, 40));
		drain();
		if (n_act - acts != 2)
			report_mismatch("ACT count", n_act - acts, 2, test_errors);
	endtask

	task automatic row_hit_test();
		int acts;
		int pres;
		int rws;
		acts = n_act;
		pres = n_pre;
		rws  = n_rw;
		send_req(1'b1, make_addr(5, 3, 20));
		send_req(1'b0, make_addr(5, 3, 33));
		send_req(1'b0, make_addr(9, 10, 1));
		drain();
		if (n_act + n_pre - acts - pres != 0)
			report_mismatch("ACT+PRE count", n_act + n_pre - acts - pres, 0, test_errors);
		if (n_rw - rws != 3)
			report_mismatch("RD/WR count", n_rw - rws, 3, test_errors);
	endtask

	task automatic row_conflict_test();
		int acts;
		int pres;
		acts = n_act;
		pres = n_pre;
		send_req(1'b0, make_addr(12, 3, 4));  // bank 3 holds row 5
		send_req(1'b1, make_addr(20, 7, 2));
		send_req(1'b0, make_addr(21, 7, 3));  // PRE right after ACT, tRAS bound
		drain();
		if (n_pre - pres != 2)
			report_mismatch("PRE count", n_pre - pres, 2, test_errors);
		if (n_act - acts != 3)
			report_mismatch("ACT count", n_act - acts, 3, test_errors);
	endtask

	task automatic refresh_test();
		int refs;
		int acts;
		int pres;
		int start;
		refs  = n_ref;
		start = cycle;
		while (n_ref == refs && cycle - start < dram_ctrl_pkg::T_REFI + 20)
			step();
		if (n_ref == refs) begin
			fail_note("no REF within the refresh interval", test_errors);
		end else begin
			acts = n_act;
			pres = n_pre;
			send_req(1'b0, make_addr(21, 7, 9)); // row was open before the REF
			drain();
			if (n_pre != pres)
				report_mismatch("PRE count after REF", n_pre - pres, 0, test_errors);
			if (n_act - acts != 1)
				report_mismatch("ACT count after REF", n_act - acts, 1, test_errors);
		end
	endtask

	task automatic full_queue_test();
		int          rws;
		logic        w;
		logic [15:0] a;
		rws = n_rw;
		cmd_ready = 1'b0; // nothing leaves the queue
		for (int i = 0; i < QUEUE_DEPTH; i++)
			send_req(1'($urandom_range(0, 1)), random_addr());
		w = 1'($urandom_range(0, 1));
		a = random_addr();
		req_valid = 1'b1;
		req_write = w;
		req_addr  = a;
		repeat (4) begin // one more request waits on a full queue
			if (req_ready !== 1'b0)
				report_mismatch("req_ready", int'(req_ready), 0, test_errors);
			step();
		end
		cmd_ready = 1'b1;
		send_req(w, a);
		for (int i = 0; i < 3; i++)
			send_req(1'($urandom_range(0, 1)), random_addr());
		drain();
		if (n_rw - rws != QUEUE_DEPTH + 4)
			report_mismatch("RD/WR count", n_rw - rws, QUEUE_DEPTH + 4, test_errors);
	endtask

	task automatic back_pressure_test();
		int rws;
		rws = n_rw;
		jitter = 1'b1;
		for (int i = 0; i < 24; i++) begin
			send_req(1'($urandom_range(0, 1)), random_addr());
			repeat ($urandom_range(0, 3)) step();
		end
		drain();
		jitter = 1'b0;
		cmd_ready = 1'b1;
		if (n_rw - rws != 24)
			report_mismatch("RD/WR count", n_rw - rws, 24, test_errors);
	endtask

	initial begin
		void'($urandom(60913));
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		cmd_ready = 1'b1;
		jitter    = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		step();
		row_miss_test();
		row_hit_test();
		row_conflict_test(); // leaves bank 7 open for the refresh test
		refresh_test();
		full_queue_test();
		back_pressure_test();
		if (exp_head != exp_addr.size())
			fail_note("requests left without a RD or WR", test_errors);
		end_run();
	end

endmodule : dram_ctrl_tb

`default_nettype wire

// ==== sim.f ====
hdl/dram_ctrl_pkg.sv
hdl/request_queue.sv
hdl/bank_state.sv
hdl/refresh_timer.sv
hdl/command_sequencer.sv
hdl/dram_ctrl_top.sv
sim/dram_ctrl_properties.sv
sim/dram_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the DRAM controller testbench
TOP := dram_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f sim.f -Mdir obj_dir

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'All tests passed!'

clean:
	rm -rf obj_dir
